// ==== loader_top.f ====
design/loader_pkg.sv
design/imem_wr_if.sv
design/rx_byte_fifo.sv
design/xmodem_loader.sv
design/instr_mem.sv
design/loader_top.sv
test/tb_loader_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_loader_top
FILELIST  ?= loader_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_loader_top;
    import loader_pkg::*;

    localparam int BEACON_CYCLES = 300;
    localparam int HOST_GAP      = 3;
    localparam int ACK_DELAY     = 2;
    localparam int RESP_WAIT     = 50;
    // Four blocks plus the padded one
    localparam int IMAGE_WORDS   = 160;
    // Eight frames of 132 bytes at 3 cycles, two beacon waits and the
    // read back come to under 5000 cycles, so this leaves a wide margin
    localparam int CYCLE_LIMIT   = 40000;

    logic               clk          = 1'b0;
    logic               i_rst        = 1'b1;
    logic [7:0]         i_rx_data    = 8'h00;
    logic               i_rx_valid   = 1'b0;
    logic               i_tx_ack     = 1'b0;
    logic [IMEM_AW-1:0] i_fetch_addr = '0;
    logic               o_tx_req;
    logic [7:0]         o_tx_data;
    logic [31:0]        o_fetch_data;
    logic               o_cpu_en;
    logic               o_rx_overflow;

    logic [7:0]  tx_q [$];
    logic [7:0]  blk_data [BLOCK_BYTES];
    logic [31:0] ref_mem [IMEM_WORDS];
    int          ref_addr;
    int          ref_base;
    bit          ref_wr_on;
    bit          ref_base_wr_on;
    int          ack_wait;
    int          cycle_cnt;
    int          test_errs;
    int          mem_errs;
    int          mem_mark;
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    logic        cmp_en = 1'b0;
    logic [31:0] cmp_exp;
    int          cmp_addr;

    always #20 clk = ~clk;

    loader_top #(
        .BEACON_CYCLES (BEACON_CYCLES)
    ) UUT (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_rx_data     (i_rx_data),
        .i_rx_valid    (i_rx_valid),
        .i_tx_ack      (i_tx_ack),
        .i_fetch_addr  (i_fetch_addr),
        .o_tx_req      (o_tx_req),
        .o_tx_data     (o_tx_data),
        .o_fetch_data  (o_fetch_data),
        .o_cpu_en      (o_cpu_en),
        .o_rx_overflow (o_rx_overflow)
    );

    ////////////////////////////////////////////////////////////
    // Host side of the transmit link
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (i_rst) begin
            i_tx_ack <= 1'b0;
            ack_wait <= 0;
        end else if (o_tx_req && !i_tx_ack) begin
            if (ack_wait == ACK_DELAY - 1) begin
                i_tx_ack <= 1'b1;
                ack_wait <= 0;
                tx_q.push_back(o_tx_data);
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end else if (!o_tx_req && i_tx_ack) begin
            i_tx_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT never finished the sequence",
                     CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Fetch data is compared one cycle after its address
    always @(negedge clk) begin
        if (cmp_en && o_fetch_data !== cmp_exp) begin
            $display("[FAIL] %s: word %0d expected %08h actual %08h",
                     cur_test, cmp_addr, cmp_exp, o_fetch_data);
            mem_errs = mem_errs + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [7:0] expected_cksum();
        logic [7:0] sum;
        sum = 8'h00;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            sum = sum + blk_data[i];
        end
        return sum;
    endfunction

    // Block writes land first, then ACK commits or NAK rewinds
    function automatic void apply_block_to_image(input bit good);
        logic [31:0] word;
        for (int w = 0; w < BLOCK_BYTES / 4; w++) begin
            word = {blk_data[4*w+3], blk_data[4*w+2], blk_data[4*w+1], blk_data[4*w]};
            if (ref_wr_on) begin
                ref_mem[ref_addr] = word;
                ref_addr = ref_addr + 1;
                if (word == PAD_WORD) begin
                    ref_wr_on = 1'b0;
                end
            end
        end
        if (good) begin
            ref_base       = ref_addr;
            ref_base_wr_on = ref_wr_on;
        end else begin
            ref_addr  = ref_base;
            ref_wr_on = ref_base_wr_on;
        end
    endfunction

    // Bytes stay in 20..FE, so none is SOT and no word is the pad
    function automatic void fill_block();
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            blk_data[i] = 8'h20 + 8'($urandom_range(222));
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Host tasks and checks
    ////////////////////////////////////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        i_rx_data  <= b;
        i_rx_valid <= 1'b1;
        @(posedge clk);
        i_rx_valid <= 1'b0;
        repeat (HOST_GAP - 2) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] blk, input logic [7:0] inv,
                              input logic [7:0] cks);
        send_byte(BYTE_SOT);
        send_byte(blk);
        send_byte(inv);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            send_byte(blk_data[i]);
        end
        send_byte(cks);
    endtask

    task automatic wait_response(input logic [7:0] exp, input int limit);
        int         n;
        logic [7:0] got;
        n = 0;
        while (tx_q.size() == 0 && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if (tx_q.size() == 0) begin
            $display("%s: no response from the DUT within %0d cycles", cur_test, limit);
            test_errs++;
        end else begin
            got = tx_q.pop_front();
            if (got !== exp) begin
                $display("[FAIL] %s: response expected %02h actual %02h", cur_test, exp, got);
                test_errs++;
            end
        end
    endtask

    task automatic check_image(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            @(posedge clk);
            cmp_en       <= 1'b0;
            i_fetch_addr <= IMEM_AW'(a);
            @(posedge clk);
            cmp_en   <= 1'b1;
            cmp_exp  <= ref_mem[a];
            cmp_addr <= a;
        end
        @(posedge clk);
        cmp_en <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
        mem_mark  = mem_errs;
        tx_q.delete();
    endtask

    task automatic finish_test();
        int errs;
        errs = test_errs + mem_errs - mem_mark;
        tests_run++;
        if (errs == 0) begin
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", cur_test, errs);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] cks;
        logic [7:0] rsp;
        void'($urandom(32'hc70f_30e1));
        ref_wr_on      = 1'b1;
        ref_base_wr_on = 1'b1;
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;

        start_test("beacon_after_reset");
        wait_response(BYTE_NAK, 2 * BEACON_CYCLES);
        if (o_cpu_en !== 1'b0) begin
            $display("%s: o_cpu_en went high before any EOT", cur_test);
            test_errs++;
        end
        finish_test();

        start_test("good_blocks");
        for (int b = 1; b <= 2; b++) begin
            fill_block();
            send_frame(8'(b), ~8'(b), expected_cksum());
            wait_response(BYTE_ACK, RESP_WAIT);
            apply_block_to_image(1'b1);
        end
        check_image(0, 63);
        finish_test();

        start_test("bad_checksum");
        fill_block();
        cks = expected_cksum();
        // First copy arrives with a damaged byte as well as a damaged checksum
        blk_data[0] = blk_data[0] ^ 8'h40;
        send_frame(8'd3, ~8'd3, cks ^ 8'hFF);
        wait_response(BYTE_NAK, RESP_WAIT);
        apply_block_to_image(1'b0);
        blk_data[0] = blk_data[0] ^ 8'h40;
        send_frame(8'd3, ~8'd3, cks);
        wait_response(BYTE_ACK, RESP_WAIT);
        apply_block_to_image(1'b1);
        check_image(64, 95);
        finish_test();

        start_test("bad_complement");
        fill_block();
        // Keep the trailing checksum byte from looking like SOT
        if (expected_cksum() == BYTE_SOT) begin
            blk_data[0] = blk_data[0] + 8'h01;
        end
        send_frame(8'd4, 8'd4, expected_cksum());
        repeat (20) @(posedge clk);
        // Loader is idle again and may only send NAK beacons
        while (tx_q.size() > 0) begin
            rsp = tx_q.pop_front();
            if (rsp !== BYTE_NAK) begin
                $display("[FAIL] %s: response expected %02h (beacon only) actual %02h",
                         cur_test, BYTE_NAK, rsp);
                test_errs++;
            end
        end
        fill_block();
        send_frame(8'd4, ~8'd4, expected_cksum());
        wait_response(BYTE_ACK, RESP_WAIT);
        apply_block_to_image(1'b1);
        check_image(96, 127);
        finish_test();

        start_test("pad_word");
        // First pass fills the region, so the words after the pad hold known data
        fill_block();
        send_frame(8'd5, ~8'd5, expected_cksum() ^ 8'h55);
        wait_response(BYTE_NAK, RESP_WAIT);
        apply_block_to_image(1'b0);
        fill_block();
        for (int i = 40; i < 44; i++) begin
            blk_data[i] = 8'h1A;
        end
        send_frame(8'd5, ~8'd5, expected_cksum());
        wait_response(BYTE_ACK, RESP_WAIT);
        apply_block_to_image(1'b1);
        check_image(128, 159);
        finish_test();

        start_test("eot");
        send_byte(BYTE_EOT);
        wait_response(BYTE_ACK, RESP_WAIT);
        @(negedge clk);
        if (o_cpu_en !== 1'b1) begin
            $display("%s: o_cpu_en stayed low after the EOT was acknowledged", cur_test);
            test_errs++;
        end
        wait_response(BYTE_PROMPT, 2 * BEACON_CYCLES);
        check_image(0, IMAGE_WORDS - 1);
        if (o_rx_overflow !== 1'b0) begin
            $display("%s: receive FIFO overflowed and dropped a byte", cur_test);
            test_errs++;
        end
        finish_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_top #(
    parameter int BEACON_CYCLES = 100_000
) (
    input  wire logic                           clk,
    input  wire logic                           i_rst,
    input  wire logic [7:0]                     i_rx_data,
    input  wire logic                           i_rx_valid,
    input  wire logic                           i_tx_ack,
    input  wire logic [loader_pkg::IMEM_AW-1:0] i_fetch_addr,
    output logic                                o_tx_req,
    output logic [7:0]                          o_tx_data,
    output logic [31:0]                         o_fetch_data,
    output logic                                o_cpu_en,
    output logic                                o_rx_overflow
);

    logic [7:0] rx_head;
    logic       rx_not_empty;
    logic       rx_pop;

    imem_wr_if wr_bus ();

    // Received bytes wait here while a response is in flight
    rx_byte_fifo u_rx_fifo (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_push      (i_rx_valid),
        .i_push_data (i_rx_data),
        .i_pop       (rx_pop),
        .o_head      (rx_head),
        .o_not_empty (rx_not_empty),
        .o_overflow  (o_rx_overflow)
    );

    xmodem_loader #(
        .BEACON_CYCLES (BEACON_CYCLES)
    ) u_loader (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_byte       (rx_head),
        .i_byte_valid (rx_not_empty),
        .i_tx_ack     (i_tx_ack),
        .o_byte_pop   (rx_pop),
        .o_tx_req     (o_tx_req),
        .o_tx_data    (o_tx_data),
        .o_cpu_en     (o_cpu_en),
        .wr           (wr_bus.source)
    );

    instr_mem u_imem (
        .clk          (clk),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch_data (o_fetch_data),
        .wr           (wr_bus.sink)
    );

endmodule

`default_nettype wire

// ==== design/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  wire logic                         clk,
    input  wire logic [loader_pkg::IMEM_AW-1:0] i_fetch_addr,
    output logic [31:0]                       o_fetch_data,
    imem_wr_if.sink                           wr
);
    import loader_pkg::*;

    logic [31:0] mem [IMEM_WORDS];

    // Loader write port
    always_ff @(posedge clk) begin
        if (wr.wen) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // CPU fetch port, one cycle of latency
    always_ff @(posedge clk) begin
        o_fetch_data <= mem[i_fetch_addr];
    end

endmodule

`default_nettype wire

// ==== design/xmodem_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module xmodem_loader #(
    parameter int BEACON_CYCLES = 1000
) (
    input  wire logic       clk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_byte,
    input  wire logic       i_byte_valid,
    input  wire logic       i_tx_ack,
    output logic            o_byte_pop,
    output logic            o_tx_req,
    output logic [7:0]      o_tx_data,
    output logic            o_cpu_en,
    imem_wr_if.source       wr
);
    import loader_pkg::*;

    loader_state_t        state;
    loader_state_t        state_next;
    logic [7:0]           blk_num;
    logic [7:0]           cksum;
    logic [BLK_CNT_W-1:0] byte_cnt;
    logic [31:0]          word_sr;
    logic [31:0]          word_next;
    logic [IMEM_AW-1:0]   wr_addr;
    logic [IMEM_AW-1:0]   blk_base;
    logic                 wr_on;
    logic                 blk_wr_on;
    logic [31:0]          beacon_cnt;
    logic                 beacon_state;
    logic                 beacon_tick;
    logic                 link_busy;
    logic                 resp_start;
    logic [7:0]           resp_byte;

    // Response in flight until ack has fallen
    assign link_busy  = o_tx_req | i_tx_ack;
    assign o_byte_pop = i_byte_valid & ~link_busy;

    // Little-endian packing puts the newest byte at the top
    assign word_next = {i_byte, word_sr[31:8]};

    assign beacon_state = (state == ST_IDLE) || (state == ST_RUN);
    assign beacon_tick  = beacon_state && (beacon_cnt == 32'(BEACON_CYCLES - 1));

    ////////////////////////////////////////////////////////////
    // Frame FSM and response select
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        resp_start = 1'b0;
        resp_byte  = BYTE_NAK;
        case (state)
            ST_IDLE: begin
                if (beacon_tick && !link_busy) begin
                    resp_start = 1'b1;
                    resp_byte  = BYTE_NAK;
                end
                if (o_byte_pop && i_byte == BYTE_SOT) begin
                    state_next = ST_BLK_NUM;
                end
            end
            ST_BLK_NUM: begin
                if (o_byte_pop) begin
                    state_next = ST_BLK_INV;
                end
            end
            ST_BLK_INV: begin
                // Bad complement drops the frame without a reply
                if (o_byte_pop) begin
                    state_next = (i_byte == ~blk_num) ? ST_DATA : ST_IDLE;
                end
            end
            ST_DATA: begin
                if (o_byte_pop && byte_cnt == BLK_CNT_W'(BLOCK_BYTES - 1)) begin
                    state_next = ST_CKSUM;
                end
            end
            ST_CKSUM: begin
                if (o_byte_pop) begin
                    resp_start = 1'b1;
                    resp_byte  = (i_byte == cksum) ? BYTE_ACK : BYTE_NAK;
                    state_next = ST_WAIT_NEXT;
                end
            end
            ST_WAIT_NEXT: begin
                if (o_byte_pop && i_byte == BYTE_SOT) begin
                    state_next = ST_BLK_NUM;
                end else if (o_byte_pop && i_byte == BYTE_EOT) begin
                    resp_start = 1'b1;
                    resp_byte  = BYTE_ACK;
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                if (beacon_tick && !link_busy) begin
                    resp_start = 1'b1;
                    resp_byte  = BYTE_PROMPT;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= ST_IDLE;
            byte_cnt  <= '0;
            wr_addr   <= '0;
            blk_base  <= '0;
            wr_on     <= 1'b1;
            blk_wr_on <= 1'b1;
            o_cpu_en  <= 1'b0;
            wr.wen    <= 1'b0;
        end else begin
            state  <= state_next;
            wr.wen <= 1'b0;
            case (state)
                ST_BLK_INV: begin
                    if (o_byte_pop) begin
                        byte_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (o_byte_pop) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // Fourth byte completes a word
                        if (byte_cnt[1:0] == 2'd3 && wr_on) begin
                            wr.wen  <= 1'b1;
                            wr_addr <= wr_addr + 1'b1;
                            if (word_next == PAD_WORD) begin
                                wr_on <= 1'b0;
                            end
                        end
                    end
                end
                ST_CKSUM: begin
                    if (o_byte_pop) begin
                        if (i_byte == cksum) begin
                            // Commit the block so the next one follows it
                            blk_base  <= wr_addr;
                            blk_wr_on <= wr_on;
                        end else begin
                            // Rewind so the resend overwrites this block
                            wr_addr <= blk_base;
                            wr_on   <= blk_wr_on;
                        end
                    end
                end
                ST_WAIT_NEXT: begin
                    if (o_byte_pop && i_byte == BYTE_EOT) begin
                        o_cpu_en <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Block number, checksum and word assembly
    always_ff @(posedge clk) begin
        if (state == ST_BLK_NUM && o_byte_pop) begin
            blk_num <= i_byte;
        end
        if (state == ST_BLK_INV && o_byte_pop) begin
            cksum <= '0;
        end
        if (state == ST_DATA && o_byte_pop) begin
            cksum    <= cksum + i_byte;
            word_sr  <= word_next;
            wr.waddr <= wr_addr;
            wr.wdata <= word_next;
            wr.last  <= (word_next == PAD_WORD);
        end
    end

    ////////////////////////////////////////////////////////////
    // Beacon timer and four-phase transmit link
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            beacon_cnt <= '0;
        end else if (!beacon_state || beacon_tick) begin
            beacon_cnt <= '0;
        end else begin
            beacon_cnt <= beacon_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_tx_req <= 1'b0;
        end else if (o_tx_req && i_tx_ack) begin
            o_tx_req <= 1'b0;
        end else if (resp_start && !link_busy) begin
            o_tx_req <= 1'b1;
        end
    end

    // Data is held until the next response starts
    always_ff @(posedge clk) begin
        if (resp_start && !link_busy) begin
            o_tx_data <= resp_byte;
        end
    end

endmodule

`default_nettype wire

// ==== design/rx_byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo (
    input  wire logic       clk,
    input  wire logic       i_rst,
    input  wire logic       i_push,
    input  wire logic [7:0] i_push_data,
    input  wire logic       i_pop,
    output logic [7:0]      o_head,
    output logic            o_not_empty,
    output logic            o_overflow
);
    import loader_pkg::*;

    logic [7:0]            mem [RX_FIFO_DEPTH];
    logic [RX_FIFO_AW-1:0] wr_ptr;
    logic [RX_FIFO_AW-1:0] rd_ptr;
    logic [RX_FIFO_AW:0]   count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full        = (count == (RX_FIFO_AW + 1)'(RX_FIFO_DEPTH));
    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];

    assign do_pop  = i_pop & o_not_empty;
    // A pop in the same cycle frees a slot for the push
    assign do_push = i_push & (~full | do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // A dropped byte sets a flag that holds until reset
            if (i_push && !do_push) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/imem_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface imem_wr_if;
    import loader_pkg::*;

    logic               wen;
    logic [IMEM_AW-1:0] waddr;
    logic [31:0]        wdata;
    // Marks the pad word, the final write of the image
    logic               last;

    modport source (
        output wen,
        output waddr,
        output wdata,
        output last
    );

    modport sink (
        input wen,
        input waddr,
        input wdata,
        input last
    );

endinterface

`default_nettype wire

// ==== design/loader_pkg.sv ====
`default_nettype none

package loader_pkg;

    ////////////////////////////////////////////////////////////
    // Protocol byte codes
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] BYTE_SOT    = 8'h01;
    localparam logic [7:0] BYTE_EOT    = 8'h04;
    localparam logic [7:0] BYTE_ACK    = 8'h06;
    localparam logic [7:0] BYTE_NAK    = 8'h15;
    // Beacon sent once the CPU runs
    localparam logic [7:0] BYTE_PROMPT = 8'h2A;

    ////////////////////////////////////////////////////////////
    // Frame and memory sizes
    ////////////////////////////////////////////////////////////
    localparam int BLOCK_BYTES = 128;
    localparam int BLK_CNT_W   = 7;

    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = 8;

    // Padding word that ends the firmware image
    localparam logic [31:0] PAD_WORD = 32'h1A1A_1A1A;

    localparam int RX_FIFO_DEPTH = 8;
    localparam int RX_FIFO_AW    = 3;

    // Loader states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BLK_NUM,
        ST_BLK_INV,
        ST_DATA,
        ST_CKSUM,
        ST_WAIT_NEXT,
        ST_RUN
    } loader_state_t;

endpackage

`default_nettype wire
